//--- dv/datapath_cases.txt
# columns: instr (hex), idle cycles before it (decimal, -1 picks 0 to 3 at random),
# then the expected retire rd_wr, rd, data and illegal (hex)
00500093 0 1 01 0000000000000005 0
ffd00113 0 1 02 fffffffffffffffd 0
7ff00193 1 1 03 00000000000007ff 0
80000213 -1 1 04 fffffffffffff800 0
002082b3 0 1 05 0000000000000002 0
40128333 0 1 06 fffffffffffffffd 0
401003b3 -1 1 07 fffffffffffffffb 0
00109433 0 1 08 00000000000000a0 0
001124b3 2 1 09 0000000000000001 0
00113533 0 1 0a 0000000000000000 0
003145b3 -1 1 0b fffffffffffff802 0
00115633 0 1 0c 07ffffffffffffff 0
401156b3 0 1 0d ffffffffffffffff 0
00126733 -1 1 0e fffffffffffff805 0
002277b3 0 1 0f fffffffffffff800 0
40425813 3 1 10 ffffffffffffff80 0
02809893 0 1 11 0000050000000000 0
06400913 -1 1 12 0000000000000064 0
00190913 0 1 12 0000000000000065 0
012909b3 0 1 13 00000000000000ca 0
41298a33 0 1 14 0000000000000065 0
fffa4a93 0 1 15 ffffffffffffff9a 0
01103823 -1 0 00 0000000000000000 0
00203c23 0 0 00 0000000000000000 0
01003b03 0 1 16 0000050000000000 0
01803b83 0 1 17 fffffffffffffffd 0
00100c13 0 1 18 0000000000000001 0
017b0cb3 0 1 19 000004fffffffffd 0
01903423 0 0 00 0000000000000000 0
00803d03 0 1 1a 000004fffffffffd 0
00700d93 -1 1 1b 0000000000000007 0
000d0e13 0 1 1c 000004fffffffffd 0
00908013 0 1 00 000000000000000e 0
00100eb3 0 1 1d 0000000000000005 0
000002ff -1 0 00 0000000000000000 1
00028f13 0 1 1e 0000000000000002 0

//--- sim.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/register_file.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/data_memory.sv
hdl/result_stage.sv
hdl/rv_datapath.sv
dv/tb_rv_datapath.sv

//--- Bender.yml
package:
  name: rv_datapath

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/rv_core_pkg.sv
      - hdl/register_file.sv
      - hdl/instr_decoder.sv
      - hdl/alu.sv
      - hdl/data_memory.sv
      - hdl/result_stage.sv
      - hdl/rv_datapath.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/tb_rv_datapath.sv

//--- dv/tb_rv_datapath.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_rv_datapath
  import rv_isa_pkg::*, rv_core_pkg::*;
();

  localparam time CLK_PERIOD    = 100ns;
  localparam time DRIVE_DLY     = 5ns;
  localparam int  RESET_CYCLES  = 3;
  localparam int  DRAIN_TIMEOUT = 20;

  // what one instruction should retire with
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic                rd_wr;
    reg_idx_t            rd;
    logic [`RV_XLEN-1:0] data;
    logic                illegal;
    // edge count after which the retire shows
    logic [31:0]         due;
  } exp_rec_t;

  logic                clk;
  logic                rst_n;
  logic [`RV_ILEN-1:0] instr;
  logic                instr_valid;
  retire_t             retire;

  logic [31:0]         cycle_cnt;
  logic [`RV_XLEN-1:0] next_pc;
  exp_rec_t            exp_q[$];
  integer              seed;
  int                  n_checked;

  rv_datapath UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .retire      (retire)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // rising edges since time zero
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(string name, logic [`RV_XLEN-1:0] exp,
                                 logic [`RV_XLEN-1:0] act);
    $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
    stop_run();
  endtask

  task automatic report_problem(string msg);
    $display("%s", msg);
    stop_run();
  endtask

  // inputs change a little after the rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic drive_idle();
    instr_valid = 1'b0;
    instr       = '0;
    wait_cycle();
  endtask

  task automatic issue_instr(logic [`RV_ILEN-1:0] word, logic rd_wr, reg_idx_t rd,
                             logic [`RV_XLEN-1:0] data, logic illegal);
    exp_rec_t rec;
    rec.pc      = next_pc;
    rec.rd_wr   = rd_wr;
    rec.rd      = rd;
    rec.data    = data;
    rec.illegal = illegal;
    // sampled on the next edge, retire two edges later
    rec.due     = cycle_cnt + 3;
    exp_q.push_back(rec);
    next_pc     = next_pc + 1;
    instr       = word;
    instr_valid = 1'b1;
    wait_cycle();
  endtask

  // 0 to 3 idle cycles
  function automatic int pick_gap();
    int unsigned r;
    r = $random(seed);
    return r % 4;
  endfunction

  // blank and comment lines carry no case
  function automatic bit is_case_line(string line);
    if (line.len() < 8) begin
      return 1'b0;
    end
    return line.getc(0) != "#";
  endfunction

  task automatic check_retire();
    exp_rec_t exp;
    if (retire.valid) begin
      assert (exp_q.size() > 0)
        else report_problem("a retire came out with no instruction outstanding");
      exp = exp_q.pop_front();
      assert (cycle_cnt == exp.due)
        else report_mismatch("retire cycle", exp.due, cycle_cnt);
      assert (retire.pc == exp.pc)
        else report_mismatch("retire.pc", exp.pc, retire.pc);
      assert (retire.illegal == exp.illegal)
        else report_mismatch("retire.illegal", exp.illegal, retire.illegal);
      assert (retire.rd_wr == exp.rd_wr)
        else report_mismatch("retire.rd_wr", exp.rd_wr, retire.rd_wr);
      // rd and data only matter for a register write
      if (exp.rd_wr) begin
        assert (retire.rd == exp.rd)
          else report_mismatch("retire.rd", exp.rd, retire.rd);
        assert (retire.data == exp.data)
          else report_mismatch("retire.data", exp.data, retire.data);
      end
      n_checked++;
    end else if ((exp_q.size() > 0) && (cycle_cnt > exp_q[0].due)) begin
      report_problem("timeout, an instruction did not retire in time");
    end
  endtask

  // retire is stable at the falling edge
  initial begin : retire_monitor
    forever begin
      @(negedge clk);
      if (rst_n) begin
        check_retire();
      end
    end
  end

  initial begin : stimulus
    int                  fd;
    string               line;
    int                  n_fields;
    logic [`RV_ILEN-1:0] word;
    int                  gap;
    logic                rd_wr_f;
    reg_idx_t            rd_f;
    logic [`RV_XLEN-1:0] data_f;
    logic                illegal_f;
    int                  waited;

    seed        = 87;
    cycle_cnt   = '0;
    next_pc     = '0;
    n_checked   = 0;
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    fd = $fopen("dv/datapath_cases.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open the case file dv/datapath_cases.txt");
    end

    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (is_case_line(line)) begin
        n_fields = $sscanf(line, "%h %d %h %h %h %h",
                           word, gap, rd_wr_f, rd_f, data_f, illegal_f);
        assert (n_fields == 6)
          else report_problem({"a case line could not be parsed: ", line});
        // negative gap asks for a random one
        if (gap < 0) begin
          gap = pick_gap();
        end
        repeat (gap) drive_idle();
        issue_instr(word, rd_wr_f, rd_f, data_f, illegal_f);
      end
    end
    $fclose(fd);
    instr_valid = 1'b0;
    instr       = '0;

    assert (next_pc > 0)
      else report_problem("the case file held no instructions");

    // drain the pipeline
    waited = 0;
    while ((exp_q.size() > 0) && (waited < DRAIN_TIMEOUT)) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() > 0) begin
      report_problem("timeout, the pipeline did not drain after the last instruction");
    end else begin
      $display("%0d retires checked", n_checked);
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- hdl/rv_datapath.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_datapath
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`RV_ILEN-1:0] instr,
  input  logic                instr_valid,
  output retire_t             retire
);

  // register file read ports
  reg_idx_t                   rf_addr_a;
  reg_idx_t                   rf_addr_b;
  logic [`RV_XLEN-1:0]        rf_data_a;
  logic [`RV_XLEN-1:0]        rf_data_b;
  // stage payloads and forwarding
  decoded_op_t                dec_q;
  exec_result_t               exe_q;
  fwd_t                       fwd_exe;
  fwd_t                       fwd_res;
  // data memory port
  logic [`RV_DMEM_ADDR_W-1:0] dm_addr;
  logic                       dm_wr_en;
  logic [`RV_XLEN-1:0]        dm_wr_data;
  logic [`RV_XLEN-1:0]        dm_rd_data;

  instr_decoder dec_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .rf_addr_a   (rf_addr_a),
    .rf_addr_b   (rf_addr_b),
    .rf_data_a   (rf_data_a),
    .rf_data_b   (rf_data_b),
    .fwd_exe     (fwd_exe),
    .fwd_res     (fwd_res),
    .dec         (dec_q)
  );

  alu alu_unit (
    .clk     (clk),
    .rst_n   (rst_n),
    .dec     (dec_q),
    .fwd_exe (fwd_exe),
    .exe     (exe_q)
  );

  result_stage res_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .exe        (exe_q),
    .dm_addr    (dm_addr),
    .dm_wr_en   (dm_wr_en),
    .dm_wr_data (dm_wr_data),
    .dm_rd_data (dm_rd_data),
    .fwd_res    (fwd_res),
    .retire     (retire)
  );

  // written from the retire record
  register_file reg_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_addr_a (rf_addr_a),
    .rd_addr_b (rf_addr_b),
    .rd_data_a (rf_data_a),
    .rd_data_b (rf_data_b),
    .wr        (retire)
  );

  data_memory dm (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr    (dm_addr),
    .wr_en   (dm_wr_en),
    .wr_data (dm_wr_data),
    .rd_data (dm_rd_data)
  );

endmodule

//--- hdl/result_stage.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module result_stage
  import rv_core_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  exec_result_t               exe,
  output logic [`RV_DMEM_ADDR_W-1:0] dm_addr,
  output logic                       dm_wr_en,
  output logic [`RV_XLEN-1:0]        dm_wr_data,
  input  logic [`RV_XLEN-1:0]        dm_rd_data,
  output fwd_t                       fwd_res,
  output retire_t                    retire
);

  logic [`RV_XLEN-1:0] wb_data;
  retire_t             retire_q;

  // doubleword index from the byte address
  assign dm_addr    = exe.value[`RV_DWORD_OFFS +: `RV_DMEM_ADDR_W];
  assign dm_wr_en   = exe.valid && exe.is_store;
  assign dm_wr_data = exe.store_data;

  // writeback select
  assign wb_data = exe.is_load ? dm_rd_data : exe.value;

  // second forwarding source, load data included
  assign fwd_res = '{valid: exe.valid && exe.rd_wr,
                     rd:    exe.rd,
                     data:  wb_data};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire_q <= '0;
    end else begin
      retire_q.valid   <= exe.valid;
      retire_q.pc      <= exe.pc;
      retire_q.rd      <= exe.rd;
      retire_q.rd_wr   <= exe.rd_wr;
      retire_q.data    <= wb_data;
      retire_q.illegal <= exe.illegal;
    end
  end

  // also the register file write
  assign retire = retire_q;

endmodule

//--- hdl/data_memory.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module data_memory (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`RV_DMEM_ADDR_W-1:0] addr,
  input  logic                       wr_en,
  input  logic [`RV_XLEN-1:0]        wr_data,
  output logic [`RV_XLEN-1:0]        rd_data
);

  // doubleword array
  logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];

  // contents come up zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[addr] <= wr_data;
    end
  end

  // combinational read
  // a load after a store to the same word sees the stored value
  assign rd_data = mem[addr];

  // a store must land on a known word
  a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(addr));

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module alu
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  decoded_op_t  dec,
  output fwd_t         fwd_exe,
  output exec_result_t exe
);

  localparam int MSB = `RV_XLEN - 1;

  alu_op_e                op;
  logic [`RV_XLEN-1:0]    a;
  logic [`RV_XLEN-1:0]    b;
  logic [`RV_XLEN-1:0]    sum;
  logic [`RV_XLEN-1:0]    diff;
  logic [`RV_XLEN-1:0]    result;
  logic [`RV_SHAMT_W-1:0] shamt;
  alu_flags_t             flags;
  exec_result_t           exe_q;

  // ld / sd use the adder for the address
  assign op    = (dec.is_load || dec.is_store) ? ALU_ADD : dec.alu_op;
  assign a     = dec.operand_a;
  assign b     = dec.operand_b;
  assign sum   = a + b;
  assign diff  = a - b;
  assign shamt = b[`RV_SHAMT_W-1:0];

  always_comb begin
    // signed overflow of the adder in use
    if (op == ALU_SUB) begin
      flags.overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
    end else begin
      flags.overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    end
    flags.equal     = (a == b);
    flags.not_equal = (a != b);
    flags.greater   = ($signed(a) > $signed(b));
    flags.less      = ($signed(a) < $signed(b));
    flags.u_equal   = (a == b);
    flags.u_greater = (a > b);
    flags.u_less    = (a < b);
  end

  always_comb begin
    case (op)
      ALU_ADD:  result = sum;
      ALU_SUB:  result = diff;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, flags.less};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, flags.u_less};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      // sign fill
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = sum;
    endcase
  end

  // load data is not known yet, so a load does not forward from here
  assign fwd_exe = '{valid: dec.valid && dec.rd_wr && !dec.is_load,
                     rd:    dec.rd,
                     data:  result};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_q <= '0;
    end else begin
      exe_q.valid      <= dec.valid;
      exe_q.pc         <= dec.pc;
      exe_q.value      <= result;
      exe_q.store_data <= dec.store_data;
      exe_q.rd         <= dec.rd;
      exe_q.rd_wr      <= dec.rd_wr;
      exe_q.is_load    <= dec.is_load;
      exe_q.is_store   <= dec.is_store;
      exe_q.illegal    <= dec.illegal;
      exe_q.flags      <= flags;
    end
  end

  assign exe = exe_q;

  // one slot per cycle, no stall or drop
  a_exe_follows_dec: assert property (@(posedge clk) disable iff (!rst_n)
    exe.valid == $past(dec.valid));

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module instr_decoder
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`RV_ILEN-1:0] instr,
  input  logic                instr_valid,
  output reg_idx_t            rf_addr_a,
  output reg_idx_t            rf_addr_b,
  input  logic [`RV_XLEN-1:0] rf_data_a,
  input  logic [`RV_XLEN-1:0] rf_data_b,
  input  fwd_t                fwd_exe,
  input  fwd_t                fwd_res,
  output decoded_op_t         dec
);

  opcode_e             opcode;
  funct3_e             funct3;
  logic [6:0]          funct7;
  logic [5:0]          funct6;
  reg_idx_t            rd;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] src_a;
  logic [`RV_XLEN-1:0] src_b;
  logic [`RV_XLEN-1:0] pc_q;
  decoded_op_t         dec_d;
  decoded_op_t         dec_q;

  // newest producer wins: execute, then result, then register file
  function automatic logic [`RV_XLEN-1:0] pick_operand(
    reg_idx_t idx, logic [`RV_XLEN-1:0] rf_val, fwd_t exe_src, fwd_t res_src);
    logic [`RV_XLEN-1:0] val;
    if (idx == '0) begin
      val = '0;
    end else if (exe_src.valid && (exe_src.rd == idx)) begin
      val = exe_src.data;
    end else if (res_src.valid && (res_src.rd == idx)) begin
      val = res_src.data;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  // field split
  assign opcode    = opcode_e'(instr[6:0]);
  assign rd        = instr[11:7];
  assign funct3    = funct3_e'(instr[14:12]);
  assign rf_addr_a = instr[19:15];
  assign rf_addr_b = instr[24:20];
  assign funct7    = instr[31:25];
  assign funct6    = instr[31:26];

  // sign-extended immediates
  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

  assign src_a = pick_operand(rf_addr_a, rf_data_a, fwd_exe, fwd_res);
  assign src_b = pick_operand(rf_addr_b, rf_data_b, fwd_exe, fwd_res);

  always_comb begin
    dec_d            = '0;
    dec_d.valid      = instr_valid;
    dec_d.pc         = pc_q;
    dec_d.alu_op     = ALU_ADD;
    dec_d.operand_a  = src_a;
    dec_d.operand_b  = src_b;
    dec_d.store_data = src_b;
    dec_d.rd         = rd;
    case (opcode)
      OP: begin
        dec_d.alu_op = alu_op_e'({funct7[5], funct3});
        dec_d.rd_wr  = 1'b1;
        // only add and srl have an alternate form
        if (funct7 == F7_ALT) begin
          dec_d.illegal = (funct3 != F3_ADD) && (funct3 != F3_SRL);
        end else if (funct7 != F7_BASE) begin
          dec_d.illegal = 1'b1;
        end
      end
      OP_IMM: begin
        dec_d.operand_b = imm_i;
        dec_d.alu_op    = alu_op_e'({1'b0, funct3});
        dec_d.rd_wr     = 1'b1;
        // shifts carry a 6-bit shamt and funct6 above it
        if (funct3 == F3_SLL) begin
          dec_d.illegal = (funct6 != F6_BASE);
        end else if (funct3 == F3_SRL) begin
          if (funct6 == F6_ALT) begin
            dec_d.alu_op = ALU_SRA;
          end else begin
            dec_d.illegal = (funct6 != F6_BASE);
          end
        end
      end
      LOAD: begin
        dec_d.operand_b = imm_i;
        dec_d.is_load   = 1'b1;
        dec_d.rd_wr     = 1'b1;
        dec_d.illegal   = (funct3 != F3_DWORD);
      end
      STORE: begin
        dec_d.operand_b = imm_s;
        dec_d.is_store  = 1'b1;
        dec_d.illegal   = (funct3 != F3_DWORD);
      end
      default: begin
        dec_d.illegal = 1'b1;
      end
    endcase
    // illegal ops pass through as no-ops
    if (dec_d.illegal) begin
      dec_d.rd_wr    = 1'b0;
      dec_d.is_load  = 1'b0;
      dec_d.is_store = 1'b0;
    end
  end

  // pc counts accepted instructions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q  <= '0;
      dec_q <= '0;
    end else begin
      dec_q <= dec_d;
      if (instr_valid) begin
        pc_q <= pc_q + 1'b1;
      end
    end
  end

  assign dec = dec_q;

  // an illegal op reaching execute never writes a register or memory
  a_illegal_no_wr: assert property (@(posedge clk) disable iff (!rst_n)
    (dec_q.valid && dec_q.illegal) |-> (!dec_q.rd_wr && !dec_q.is_store));

endmodule

//--- hdl/register_file.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module register_file
  import rv_isa_pkg::*, rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  reg_idx_t            rd_addr_a,
  input  reg_idx_t            rd_addr_b,
  output logic [`RV_XLEN-1:0] rd_data_a,
  output logic [`RV_XLEN-1:0] rd_data_b,
  input  retire_t             wr
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];
  logic                wr_hit;

  // x0 is never stored
  assign wr_hit = wr.valid && wr.rd_wr && (wr.rd != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // read ports
  // write-through so a read in the retire cycle sees the new value
  // x0 keeps its reset zero
  assign rd_data_a = (wr_hit && (wr.rd == rd_addr_a)) ? wr.data : regs[rd_addr_a];
  assign rd_data_b = (wr_hit && (wr.rd == rd_addr_b)) ? wr.data : regs[rd_addr_b];

  // x0 reads zero on both ports, also while retire targets it
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    ((rd_addr_a != '0) || (rd_data_a == '0)) && ((rd_addr_b != '0) || (rd_data_b == '0)));

endmodule

//--- hdl/rv_core_pkg.sv
`include "rv_defs.svh"

package rv_core_pkg;
  import rv_isa_pkg::*;

  // comparison and overflow flags from execute
  typedef struct packed {
    logic overflow;
    logic equal;
    logic not_equal;
    logic greater;
    logic less;
    logic u_equal;
    logic u_greater;
    logic u_less;
  } alu_flags_t;

  // decode -> execute
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    alu_op_e             alu_op;
    logic [`RV_XLEN-1:0] operand_a;
    logic [`RV_XLEN-1:0] operand_b;
    logic [`RV_XLEN-1:0] store_data;
    reg_idx_t            rd;
    logic                rd_wr;
    logic                is_load;
    logic                is_store;
    logic                illegal;
  } decoded_op_t;

  // execute -> result
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    // alu result, or byte address for ld / sd
    logic [`RV_XLEN-1:0] value;
    logic [`RV_XLEN-1:0] store_data;
    reg_idx_t            rd;
    logic                rd_wr;
    logic                is_load;
    logic                is_store;
    logic                illegal;
    alu_flags_t          flags;
  } exec_result_t;

  // retire record, also the register file write port
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    reg_idx_t            rd;
    logic                rd_wr;
    logic [`RV_XLEN-1:0] data;
    logic                illegal;
  } retire_t;

  // one forwarding source into decode
  typedef struct packed {
    logic                valid;
    reg_idx_t            rd;
    logic [`RV_XLEN-1:0] data;
  } fwd_t;

endpackage

//--- hdl/rv_isa_pkg.sv
`include "rv_defs.svh"

package rv_isa_pkg;

  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // funct3 of the integer alu group
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SRL  = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  // ld / sd width code
  localparam logic [2:0] F3_DWORD = 3'b011;

  // funct7 of OP, alternate form selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // funct6 of the rv64 immediate shifts
  localparam logic [5:0] F6_BASE = 6'b000000;
  localparam logic [5:0] F6_ALT  = 6'b010000;

  // msb is the alternate-form bit, low bits follow funct3
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

endpackage

//--- hdl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data word width
`define RV_XLEN 64
// instruction word width
`define RV_ILEN 32
// architectural integer registers
`define RV_NREGS 32
// bits of a register index
`define RV_REG_IDX_W 5
// data memory depth, in doublewords
`define RV_DMEM_WORDS 32
// doubleword address bits
`define RV_DMEM_ADDR_W 5
// low address bits that pick a byte inside a doubleword
`define RV_DWORD_OFFS 3
// rv64 shift amount width
`define RV_SHAMT_W 6

`endif
